//--- include/adder_macros.svh
`ifndef ADDER_MACROS_SVH
`define ADDER_MACROS_SVH

// Operand width of the prefix adder. The sparse tree levels are laid out for
// exactly this width.
`define ADD_WIDTH 10

// Wishbone data and address widths.
`define WB_DATA_WIDTH 32
`define WB_ADR_WIDTH 4

// Register word offsets, taken from address bits 3 down to 2.
`define REG_OPA 2'd0
`define REG_OPB 2'd1
`define REG_CMD 2'd2
`define REG_RES 2'd3

// Command word opcode field.
`define CMD_OP_BITS 2

`endif

//--- logic/alu_types_pkg.sv
`include "adder_macros.svh"

package alu_types_pkg;

    // Code 3 is reserved and executes as OP_ADD.
    typedef enum logic [`CMD_OP_BITS-1:0] {
        OP_ADD  = 2'd0,
        OP_ADDC = 2'd1,
        OP_SUB  = 2'd2
    } alu_op_t;

    // Flag positions in the result word, just above the sum.
    localparam int FLAG_CARRY = `ADD_WIDTH;
    localparam int FLAG_OVF   = `ADD_WIDTH + 1;
    localparam int FLAG_ZERO  = `ADD_WIDTH + 2;

endpackage

//--- logic/wb_types_pkg.sv
`include "adder_macros.svh"

package wb_types_pkg;

    // Register select, decoded from the word address.
    typedef enum logic [1:0] {
        REG_SEL_OPA = `REG_OPA,
        REG_SEL_OPB = `REG_OPB,
        REG_SEL_CMD = `REG_CMD,
        REG_SEL_RES = `REG_RES
    } wb_reg_t;

    // The slave acks every request in the cycle after it is seen.
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_ACK  = 1'b1
    } wb_state_t;

endpackage

//--- logic/bk_prefix_tree.sv
`timescale 1ns/1ps
`include "adder_macros.svh"

module bk_prefix_tree (
    input  logic [`ADD_WIDTH:1] p,
    input  logic [`ADD_WIDTH:1] g,
    output logic [`ADD_WIDTH:1] grp_p,
    output logic [`ADD_WIDTH:1] grp_g
);

    logic [`ADD_WIDTH:1] p_l1, g_l1;
    logic [`ADD_WIDTH:1] p_l2, g_l2;
    logic [`ADD_WIDTH:1] p_l3, g_l3;
    logic [`ADD_WIDTH:1] p_l4, g_l4;

    // Up-sweep. Each level merges a node with the one a power of two below it.
    for (genvar i = 1; i <= `ADD_WIDTH; i++) begin : g_lvl1
        if (i % 2 == 0) begin : g_op
            assign p_l1[i] = p[i] & p[i-1];
            assign g_l1[i] = g[i] | (p[i] & g[i-1]);
        end else begin : g_pass
            assign p_l1[i] = p[i];
            assign g_l1[i] = g[i];
        end
    end

    for (genvar i = 1; i <= `ADD_WIDTH; i++) begin : g_lvl2
        if (i % 4 == 0) begin : g_op
            assign p_l2[i] = p_l1[i] & p_l1[i-2];
            assign g_l2[i] = g_l1[i] | (p_l1[i] & g_l1[i-2]);
        end else begin : g_pass
            assign p_l2[i] = p_l1[i];
            assign g_l2[i] = g_l1[i];
        end
    end

    for (genvar i = 1; i <= `ADD_WIDTH; i++) begin : g_lvl3
        if (i % 8 == 0) begin : g_op
            assign p_l3[i] = p_l2[i] & p_l2[i-4];
            assign g_l3[i] = g_l2[i] | (p_l2[i] & g_l2[i-4]);
        end else begin : g_pass
            assign p_l3[i] = p_l2[i];
            assign g_l3[i] = g_l2[i];
        end
    end

    // Down-sweep. Positions 6 and 10 pick up the prefix ending two bits lower.
    for (genvar i = 1; i <= `ADD_WIDTH; i++) begin : g_lvl4
        if (i >= 6 && (i - 6) % 4 == 0) begin : g_op
            assign p_l4[i] = p_l3[i] & p_l3[i-2];
            assign g_l4[i] = g_l3[i] | (p_l3[i] & g_l3[i-2]);
        end else begin : g_pass
            assign p_l4[i] = p_l3[i];
            assign g_l4[i] = g_l3[i];
        end
    end

    // Odd positions from 3 up finish against the complete even prefix below.
    for (genvar i = 1; i <= `ADD_WIDTH; i++) begin : g_lvl5
        if (i >= 3 && i % 2 == 1) begin : g_op
            assign grp_p[i] = p_l4[i] & p_l4[i-1];
            assign grp_g[i] = g_l4[i] | (p_l4[i] & g_l4[i-1]);
        end else begin : g_pass
            assign grp_p[i] = p_l4[i];
            assign grp_g[i] = g_l4[i];
        end
    end

endmodule

//--- logic/prefix_adder.sv
`timescale 1ns/1ps
`include "adder_macros.svh"

module prefix_adder
    import alu_types_pkg::*;
(
    input  logic [`ADD_WIDTH-1:0] opa,
    input  logic [`ADD_WIDTH-1:0] opb,
    input  alu_op_t               op,
    input  logic                  carry_in,
    output logic [`ADD_WIDTH-1:0] sum,
    output logic                  carry_out,
    output logic                  overflow
);

    logic [`ADD_WIDTH-1:0] opb_eff;
    logic                  cin_eff;
    logic [`ADD_WIDTH:1]   bit_p;
    logic [`ADD_WIDTH:1]   bit_g;
    logic [`ADD_WIDTH:1]   grp_p;
    logic [`ADD_WIDTH:1]   grp_g;

    // carry[i] is the carry out of bit i in 1-based numbering.
    // carry[0] is the carry into the LSB.
    logic [`ADD_WIDTH:0]   carry;

    // Subtract is A plus the ones complement of B plus one.
    always_comb begin
        opb_eff = opb;
        cin_eff = 1'b0;
        case (op)
            OP_SUB: begin
                opb_eff = ~opb;
                cin_eff = 1'b1;
            end
            OP_ADDC: begin
                cin_eff = carry_in;
            end
            default: begin
                cin_eff = 1'b0;
            end
        endcase
    end

    assign bit_p = opa ^ opb_eff;
    assign bit_g = opa & opb_eff;

    bk_prefix_tree u_tree (
        .p     (bit_p),
        .g     (bit_g),
        .grp_p (grp_p),
        .grp_g (grp_g)
    );

    assign carry[0] = cin_eff;

    for (genvar i = 1; i <= `ADD_WIDTH; i++) begin : g_carry
        assign carry[i] = grp_g[i] | (grp_p[i] & cin_eff);
    end

    assign sum = bit_p ^ carry[`ADD_WIDTH-1:0];

    assign carry_out = carry[`ADD_WIDTH];

    // Signed overflow shows as a mismatch between the carries in and out of the MSB.
    assign overflow = carry[`ADD_WIDTH] ^ carry[`ADD_WIDTH-1];

endmodule

//--- logic/adder_regs.sv
`timescale 1ns/1ps
`include "adder_macros.svh"

module adder_regs
    import alu_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`WB_ADR_WIDTH-1:0]  wb_adr,
    input  logic [`WB_DATA_WIDTH-1:0] wb_dat_w,
    output logic [`WB_DATA_WIDTH-1:0] wb_dat_r,
    output logic                      wb_ack,
    output logic [`ADD_WIDTH-1:0]     opa,
    output logic [`ADD_WIDTH-1:0]     opb,
    output alu_op_t                   op,
    output logic                      carry_in,
    input  logic [`ADD_WIDTH-1:0]     sum,
    input  logic                      carry_out,
    input  logic                      overflow
);

    localparam int PAD_W = `WB_DATA_WIDTH - `ADD_WIDTH;
    localparam int CMD_PAD_W = `WB_DATA_WIDTH - `CMD_OP_BITS;

    wb_state_t                  state;
    wb_reg_t                    reg_sel;
    logic                       req;
    logic                       wr_en;
    logic                       rd_en;
    logic                       start;
    logic [`ADD_WIDTH-1:0]      res_sum;
    logic                       res_carry;
    logic                       res_ovf;
    logic                       res_zero;
    logic [`WB_DATA_WIDTH-1:0]  res_word;
    logic [`WB_DATA_WIDTH-1:0]  rd_word;

    // Bits 1:0 are the byte lane within a word and play no part in decoding.
    assign reg_sel = wb_reg_t'(wb_adr[3:2]);

    // A strobe that is still high during the ack cycle is not a new request.
    assign req   = wb_cyc && wb_stb && (state == ST_IDLE);
    assign wr_en = req && wb_we;
    assign rd_en = req && !wb_we;

    assign wb_ack = (state == ST_ACK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req) state <= ST_ACK;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Writes land on the edge that raises ack.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opa   <= '0;
            opb   <= '0;
            op    <= OP_ADD;
            start <= 1'b0;
        end else begin
            start <= wr_en && (reg_sel == REG_SEL_CMD);
            if (wr_en) begin
                case (reg_sel)
                    REG_SEL_OPA: opa <= wb_dat_w[`ADD_WIDTH-1:0];
                    REG_SEL_OPB: opb <= wb_dat_w[`ADD_WIDTH-1:0];
                    REG_SEL_CMD: op  <= alu_op_t'(wb_dat_w[`CMD_OP_BITS-1:0]);
                    default: ;
                endcase
            end
        end
    end

    // The adder settles during the ack cycle of the command write and is
    // sampled on the edge that closes it.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_sum   <= '0;
            res_carry <= 1'b0;
            res_ovf   <= 1'b0;
            res_zero  <= 1'b0;
            carry_in  <= 1'b0;
        end else if (start) begin
            res_sum   <= sum;
            res_carry <= carry_out;
            res_ovf   <= overflow;
            res_zero  <= (sum == '0);
            carry_in  <= carry_out;
        end
    end

    always_comb begin
        res_word             = '0;
        res_word[`ADD_WIDTH-1:0] = res_sum;
        res_word[FLAG_CARRY] = res_carry;
        res_word[FLAG_OVF]   = res_ovf;
        res_word[FLAG_ZERO]  = res_zero;
    end

    always_comb begin
        case (reg_sel)
            REG_SEL_OPA: rd_word = {{PAD_W{1'b0}}, opa};
            REG_SEL_OPB: rd_word = {{PAD_W{1'b0}}, opb};
            REG_SEL_CMD: rd_word = {{CMD_PAD_W{1'b0}}, op};
            default:     rd_word = res_word;
        endcase
    end

    // Read data is registered with the request so it is valid while ack is high.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_dat_r <= '0;
        end else if (rd_en) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

//--- logic/adder_top.sv
`timescale 1ns/1ps
`include "adder_macros.svh"

module adder_top
    import alu_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`WB_ADR_WIDTH-1:0]  wb_adr,
    input  logic [`WB_DATA_WIDTH-1:0] wb_dat_w,
    output logic [`WB_DATA_WIDTH-1:0] wb_dat_r,
    output logic                      wb_ack
);

    logic [`ADD_WIDTH-1:0] opa;
    logic [`ADD_WIDTH-1:0] opb;
    alu_op_t               op;
    logic                  carry_in;
    logic [`ADD_WIDTH-1:0] sum;
    logic                  carry_out;
    logic                  overflow;

    adder_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .opa       (opa),
        .opb       (opb),
        .op        (op),
        .carry_in  (carry_in),
        .sum       (sum),
        .carry_out (carry_out),
        .overflow  (overflow)
    );

    prefix_adder u_adder (
        .opa       (opa),
        .opb       (opb),
        .op        (op),
        .carry_in  (carry_in),
        .sum       (sum),
        .carry_out (carry_out),
        .overflow  (overflow)
    );

endmodule

//--- tb/adder_checker.sv
`timescale 1ns/1ps
`include "adder_macros.svh"

module adder_checker
    import alu_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`WB_ADR_WIDTH-1:0]  wb_adr,
    input  logic [`WB_DATA_WIDTH-1:0] wb_dat_w,
    input  logic [`WB_DATA_WIDTH-1:0] wb_dat_r,
    input  logic                      wb_ack,
    output int                        error_count,
    output int                        check_count
);

    logic [`ADD_WIDTH-1:0]     m_opa;
    logic [`ADD_WIDTH-1:0]     m_opb;
    logic [`CMD_OP_BITS-1:0]   m_op;
    logic                      m_carry;
    logic [`WB_DATA_WIDTH-1:0] m_res;
    logic                      ack_prev;
    logic                      req_wait;
    wb_reg_t                   sel;
    logic [`WB_DATA_WIDTH-1:0] expected;

    function automatic string reg_name(input wb_reg_t r);
        case (r)
            REG_SEL_OPA: return "OPA";
            REG_SEL_OPB: return "OPB";
            REG_SEL_CMD: return "CMD";
            default:     return "RES";
        endcase
    endfunction

    // Subtract adds the complement of B plus one, add with carry uses the
    // stored carry, and code 3 behaves as add.
    function automatic logic [`WB_DATA_WIDTH-1:0] model_result(
        input logic [`ADD_WIDTH-1:0]   a,
        input logic [`ADD_WIDTH-1:0]   b,
        input logic [`CMD_OP_BITS-1:0] code,
        input logic                    cin
    );
        logic [`ADD_WIDTH-1:0]     b_eff;
        logic                      c0;
        logic [`ADD_WIDTH:0]       full;
        logic [`WB_DATA_WIDTH-1:0] word;
        b_eff = b;
        c0 = 1'b0;
        if (code == OP_SUB) begin
            b_eff = ~b;
            c0 = 1'b1;
        end else if (code == OP_ADDC) begin
            c0 = cin;
        end
        full = {1'b0, a} + {1'b0, b_eff} + {{`ADD_WIDTH{1'b0}}, c0};
        word = '0;
        word[`ADD_WIDTH-1:0] = full[`ADD_WIDTH-1:0];
        word[FLAG_CARRY] = full[`ADD_WIDTH];
        // Signed overflow means both inputs share a sign that the sum does not.
        word[FLAG_OVF] = (a[`ADD_WIDTH-1] == b_eff[`ADD_WIDTH-1]) &&
                         (full[`ADD_WIDTH-1] != a[`ADD_WIDTH-1]);
        word[FLAG_ZERO] = (full[`ADD_WIDTH-1:0] == '0);
        return word;
    endfunction

    // Bus signals and read data are stable at the falling edge of the ack cycle.
    always @(negedge clk) begin
        if (!arst_n) begin
            m_opa = '0;
            m_opb = '0;
            m_op = '0;
            m_carry = 1'b0;
            m_res = '0;
            ack_prev = 1'b0;
            req_wait = 1'b0;
            error_count = 0;
            check_count = 0;
        end else begin
            if (wb_ack && ack_prev) begin
                $display("Bus protocol error at %0t ns: ack stayed high for more than one cycle.",
                         $time);
                error_count = error_count + 1;
            end
            if (wb_cyc && wb_stb && !wb_ack && req_wait) begin
                $display("Bus protocol error at %0t ns: no ack in the cycle after the request.",
                         $time);
                error_count = error_count + 1;
            end
            if (wb_ack && wb_cyc && wb_stb && !ack_prev) begin
                sel = wb_reg_t'(wb_adr[3:2]);
                if (wb_we) begin
                    case (sel)
                        REG_SEL_OPA: m_opa = wb_dat_w[`ADD_WIDTH-1:0];
                        REG_SEL_OPB: m_opb = wb_dat_w[`ADD_WIDTH-1:0];
                        REG_SEL_CMD: begin
                            m_op = wb_dat_w[`CMD_OP_BITS-1:0];
                            m_res = model_result(m_opa, m_opb, m_op, m_carry);
                            m_carry = m_res[FLAG_CARRY];
                        end
                        default: ;
                    endcase
                end else begin
                    expected = '0;
                    case (sel)
                        REG_SEL_OPA: expected[`ADD_WIDTH-1:0] = m_opa;
                        REG_SEL_OPB: expected[`ADD_WIDTH-1:0] = m_opb;
                        REG_SEL_CMD: expected[`CMD_OP_BITS-1:0] = m_op;
                        default:     expected = m_res;
                    endcase
                    check_count = check_count + 1;
                    if (wb_dat_r !== expected) begin
                        $display("[ERROR] %0t ns: %s expected 0x%08h, actual 0x%08h",
                                 $time, reg_name(sel), expected, wb_dat_r);
                        error_count = error_count + 1;
                    end
                end
            end
            req_wait = wb_cyc && wb_stb && !wb_ack;
            ack_prev = wb_ack;
        end
    end

endmodule

//--- tb/adder_tb.sv
`timescale 1ns/1ps
`include "adder_macros.svh"

module adder_tb
    import alu_types_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int N_RAND       = 200;
    localparam int N_CHAINS     = 20;
    localparam int CHAIN_LEN    = 4;
    localparam int PAD_W        = `WB_DATA_WIDTH - `ADD_WIDTH;
    localparam int CMD_PAD_W    = `WB_DATA_WIDTH - `CMD_OP_BITS;
    localparam int TOTAL_TXN    = 4 + 8 + 2 * (N_RAND + 2) * 4 +
                                  N_CHAINS * (CHAIN_LEN + 1) * 4;
    localparam int WATCHDOG_NS  = TOTAL_TXN * 4 * CLK_PERIOD +
                                  (RESET_CYCLES + 100) * CLK_PERIOD;

    logic                      clk;
    logic                      arst_n;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`WB_ADR_WIDTH-1:0]  wb_adr;
    logic [`WB_DATA_WIDTH-1:0] wb_dat_w;
    logic [`WB_DATA_WIDTH-1:0] wb_dat_r;
    logic                      wb_ack;
    int                        err_cnt;
    int                        chk_cnt;
    int                        reads_issued;
    int                        err_base;
    int                        chk_base;
    logic [31:0]               lfsr_state;

    adder_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    adder_checker u_chk (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .error_count (err_cnt),
        .check_count (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [1:0] draw_op();
        logic [31:0] raw;
        do begin
            raw = draw_bits(2);
        end while (raw[1:0] == 2'd3);
        return raw[1:0];
    endfunction

    task automatic bus_cycle(input logic [1:0] reg_idx, input logic we,
                             input logic [`WB_DATA_WIDTH-1:0] data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = {reg_idx, 2'b00};
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        // Hold the request through the ack cycle, then idle.
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] reg_idx, input logic [`WB_DATA_WIDTH-1:0] data);
        bus_cycle(reg_idx, 1'b1, data);
    endtask

    task automatic bus_read(input logic [1:0] reg_idx);
        reads_issued = reads_issued + 1;
        bus_cycle(reg_idx, 1'b0, '0);
    endtask

    task automatic apply_operation(input logic [`ADD_WIDTH-1:0] a,
                                   input logic [`ADD_WIDTH-1:0] b, input logic [1:0] code);
        bus_write(`REG_OPA, {{PAD_W{1'b0}}, a});
        bus_write(`REG_OPB, {{PAD_W{1'b0}}, b});
        bus_write(`REG_CMD, {{CMD_PAD_W{1'b0}}, code});
        bus_read(`REG_RES);
    endtask

    task automatic begin_test();
        err_base = err_cnt;
        chk_base = chk_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %s done: %0d reads checked, %0d errors",
                 name, chk_cnt - chk_base, err_cnt - err_base);
    endtask

    task automatic test_reset_values();
        begin_test();
        bus_read(`REG_OPA);
        bus_read(`REG_OPB);
        bus_read(`REG_CMD);
        bus_read(`REG_RES);
        end_test("reset values");
    endtask

    task automatic test_readback();
        logic [31:0] raw;
        begin_test();
        raw = draw_bits(32);
        bus_write(`REG_OPA, raw | 32'hffff_fc00);
        bus_read(`REG_OPA);
        raw = draw_bits(32);
        bus_write(`REG_OPB, raw | 32'h8000_0400);
        bus_read(`REG_OPB);
        raw = draw_bits(32);
        bus_write(`REG_CMD, {raw[31:2], OP_SUB});
        bus_read(`REG_CMD);
        raw = draw_bits(32);
        bus_write(`REG_RES, raw);
        bus_read(`REG_RES);
        end_test("register readback");
    endtask

    task automatic test_random_op(input logic [1:0] code, input string name);
        logic [31:0] ra;
        logic [31:0] rb;
        begin_test();
        if (code == OP_SUB) begin
            apply_operation(10'h000, 10'h001, code);
            apply_operation(10'h200, 10'h001, code);
        end else begin
            apply_operation(10'h3ff, 10'h001, code);
            apply_operation(10'h1ff, 10'h001, code);
        end
        for (int i = 0; i < N_RAND; i++) begin
            ra = draw_bits(`ADD_WIDTH);
            rb = draw_bits(`ADD_WIDTH);
            apply_operation(ra[`ADD_WIDTH-1:0], rb[`ADD_WIDTH-1:0], code);
        end
        end_test(name);
    endtask

    task automatic test_carry_chains();
        logic [31:0] ra;
        logic [31:0] rb;
        begin_test();
        for (int c = 0; c < N_CHAINS; c++) begin
            // The first two chains start from a known carry of one.
            if (c == 0) begin
                apply_operation(10'd5, 10'd3, OP_SUB);
            end else if (c == 1) begin
                apply_operation(10'h3ff, 10'h001, OP_ADD);
            end else begin
                ra = draw_bits(`ADD_WIDTH);
                rb = draw_bits(`ADD_WIDTH);
                apply_operation(ra[`ADD_WIDTH-1:0], rb[`ADD_WIDTH-1:0], draw_op());
            end
            for (int s = 0; s < CHAIN_LEN; s++) begin
                ra = draw_bits(`ADD_WIDTH);
                rb = draw_bits(`ADD_WIDTH);
                if (c == 0 && s == 0) begin
                    apply_operation(10'h3ff, 10'h000, OP_ADDC);
                end else begin
                    apply_operation(ra[`ADD_WIDTH-1:0], rb[`ADD_WIDTH-1:0], OP_ADDC);
                end
            end
        end
        end_test("add with carry chains");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr_state = 32'hde78;
        arst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        reads_issued = 0;
        err_base = 0;
        chk_base = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_values();
        test_readback();
        test_random_op(OP_ADD, "random add");
        test_random_op(OP_SUB, "random subtract");
        test_carry_chains();

        @(posedge clk);
        #1;
        $display("summary: %0d reads issued, %0d checked, %0d errors",
                 reads_issued, chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt == reads_issued && chk_cnt > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (chk_cnt != reads_issued) begin
                $display("The checker saw %0d reads but %0d were issued.",
                         chk_cnt, reads_issued);
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
logic/alu_types_pkg.sv
logic/wb_types_pkg.sv
logic/bk_prefix_tree.sv
logic/prefix_adder.sv
logic/adder_regs.sv
logic/adder_top.sv
tb/adder_checker.sv
tb/adder_tb.sv

//--- Makefile
# Verilator flow for the prefix adder project.

VERILATOR ?= verilator
TOP       ?= adder_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the simulator output.
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
